//--- verif/mult_stim.txt
# issue tag dest mcand mplier product (hex) | wait cycles (decimal)
# head index (hex) | rollback index (hex)
issue 0 01 00000003 00000005 000000000000000f
wait 10
issue 1 02 0000ffff 0000ffff 00000000fffe0001
issue 2 03 ffffffff ffffffff fffffffe00000001
issue 3 04 12345678 00000010 0000000123456780
issue 4 05 80000000 00000002 0000000100000000
issue 5 06 00010000 00010000 0000000100000000
issue 6 07 deadbeef 00000000 0000000000000000
issue 7 08 ffffffff 00000002 00000001fffffffe
wait 20
head 8
issue 8 10 00000100 00000100 0000000000010000
issue 9 11 0000000a 0000000b 000000000000006e
issue a 12 00000002 00000003 0000000000000006
issue b 13 00000004 00000004 0000000000000010
issue c 14 00000005 00000005 0000000000000019
rollback 9
wait 20
issue d 15 00001000 00001000 0000000001000000
issue e 16 7fffffff 00000002 00000000fffffffe
issue f 17 00000009 00000009 0000000000000051
wait 3
rollback d
wait 20
head e
issue e 18 00000003 00000007 0000000000000015
issue f 19 11111111 0000000f 00000000ffffffff
issue 0 1a 00000010 00000010 0000000000000100
issue 1 1b 00000020 00000020 0000000000000400
rollback f
wait 20
head 0
issue 0 3f 00000007 00000006 000000000000002a
wait 20

//--- vlog.f
verilog/mult_pkg.sv
verilog/mult_unit.sv
verilog/mult_issue.sv
verilog/cdb_arbiter.sv
verilog/mult_cluster.sv
verif/mult_cluster_assert.sv
verif/mult_cluster_tb.sv

//--- Makefile
# Verilator build and run of the multiply cluster testbench

SRC := $(shell grep -v '^+' vlog.f)

.PHONY: run clean

run: obj_dir/Vmult_cluster_tb
	./obj_dir/Vmult_cluster_tb +verilator+error+limit+100 2>&1 | tee sim.log
	grep -qx "test passed" sim.log

obj_dir/Vmult_cluster_tb: vlog.f $(SRC)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module mult_cluster_tb -f vlog.f -o Vmult_cluster_tb

clean:
	rm -rf obj_dir sim.log

//--- verif/mult_cluster_tb.sv
// testbench for the multiply cluster, file driven, with a scoreboard per rob tag
`timescale 1ns/10ps
`default_nettype none

module mult_cluster_tb;

  import mult_pkg::*;

  localparam int    NUM_MULT  = 3;
  localparam int    NUM_STAGE = 4;
  localparam int    DRAIN     = 40;  // idle cycles after the last line
  localparam string STIM_FILE = "verif/mult_stim.txt";

  logic     clock;
  logic     reset;
  logic     issue_valid;
  rob_idx_t issue_rob_idx;
  pr_idx_t  issue_dest_pr;
  operand_t issue_mcand;
  operand_t issue_mplier;
  rob_idx_t rob_head;
  logic     rollback_en;
  rob_idx_t rollback_idx;
  logic     issue_ready;
  logic     cdb_valid;
  rob_idx_t cdb_rob_idx;
  pr_idx_t  cdb_dest_pr;
  product_t cdb_value;

  // scoreboard, one entry per rob tag
  product_t exp_value  [NUM_ROB];
  pr_idx_t  exp_dest   [NUM_ROB];
  int       issue_edge [NUM_ROB];
  logic     pending    [NUM_ROB];
  logic     squashed   [NUM_ROB];
  logic     isolated   [NUM_ROB];  // issued into an empty cluster

  int edge_cnt     = 0;
  int cycle_limit  = 100;
  int issue_count  = 0;
  int done_count   = 0;
  int squash_count = 0;

  mult_cluster #(
    .NUM_MULT  (NUM_MULT),
    .NUM_STAGE (NUM_STAGE)
  ) u_mult_cluster (
    .clock         (clock),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_rob_idx (issue_rob_idx),
    .issue_dest_pr (issue_dest_pr),
    .issue_mcand   (issue_mcand),
    .issue_mplier  (issue_mplier),
    .rob_head      (rob_head),
    .rollback_en   (rollback_en),
    .rollback_idx  (rollback_idx),
    .issue_ready   (issue_ready),
    .cdb_valid     (cdb_valid),
    .cdb_rob_idx   (cdb_rob_idx),
    .cdb_dest_pr   (cdb_dest_pr),
    .cdb_value     (cdb_value)
  );

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock)
  begin
    edge_cnt <= edge_cnt + 1;
    if (edge_cnt > cycle_limit)
    begin
      $display("timeout after %0d cycles with results still outstanding", edge_cnt);
      $display("test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("mismatch %s expected %0h actual %0h", name, expected, actual);
      $display("test failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  // distance from the head around the rob ring
  function automatic int rob_age(input int tag, input int head);
    return (tag - head + NUM_ROB) % NUM_ROB;
  endfunction

  function automatic int count_pending();
    int n;
    n = 0;
    for (int t = 0; t < NUM_ROB; t++)
      if (pending[t])
        n++;
    return n;
  endfunction

  //////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////

  task automatic send_issue(input rob_idx_t tag, input pr_idx_t dest, input operand_t mc,
                            input operand_t mp, input product_t prod);
    @(negedge clock);
    while (!issue_ready)  // ready level, read mid cycle
    begin
      @(posedge clock);
      issue_valid <= 1'b0;
      rollback_en <= 1'b0;
      @(negedge clock);
    end
    @(posedge clock);
    rollback_en <= 1'b0;
    isolated[tag]  = (count_pending() == 0);
    exp_value[tag] = prod;
    exp_dest[tag]  = dest;
    pending[tag]   = 1'b1;
    squashed[tag]  = 1'b0;
    issue_count++;
    issue_valid   <= 1'b1;
    issue_rob_idx <= tag;
    issue_dest_pr <= dest;
    issue_mcand   <= mc;
    issue_mplier  <= mp;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clock);
      issue_valid <= 1'b0;
      rollback_en <= 1'b0;
    end
  endtask

  task automatic move_head(input rob_idx_t head);
    @(posedge clock);
    issue_valid <= 1'b0;
    rollback_en <= 1'b0;
    rob_head    <= head;
  endtask

  task automatic send_rollback(input rob_idx_t idx);
    @(posedge clock);
    issue_valid  <= 1'b0;
    rollback_en  <= 1'b1;  // one cycle, next line clears it
    rollback_idx <= idx;
  endtask

  //////////////////////////////////////////////////
  // bus monitor
  //////////////////////////////////////////////////

  always @(negedge clock)
  begin
    int tag;
    int latency;
    if (!reset)
    begin
      if (u_mult_cluster.u_assert.error_count != 0)
      begin
        $display("protocol assertion failed by cycle %0d", edge_cnt);
        $display("test failed");
        $fatal(1, "protocol assertions failed");
      end
      // a granted unit never freezes, and without a done result none is frozen
      check("issue_ready", 64'(1), 64'(issue_ready));
      if (issue_valid)
        issue_edge[issue_rob_idx] = edge_cnt + 1;  // dut samples at the next edge
      if (cdb_valid)
      begin
        tag     = int'(cdb_rob_idx);
        latency = edge_cnt - issue_edge[tag];
        check($sformatf("%s tag %0d", squashed[tag] ? "squashed" : "pending", tag),
              64'(1), 64'(pending[tag]));
        check($sformatf("cdb_value tag %0d", tag), exp_value[tag], cdb_value);
        check($sformatf("cdb_dest_pr tag %0d", tag), 64'(exp_dest[tag]), 64'(cdb_dest_pr));
        if (isolated[tag])
          check($sformatf("latency tag %0d", tag), 64'(NUM_STAGE), 64'(latency));
        else
          check($sformatf("min latency tag %0d", tag), 64'(1), 64'(latency >= NUM_STAGE));
        pending[tag] = 1'b0;
        done_count++;
      end
      // whatever is on the bus now has completed, the younger rest dies
      if (rollback_en)
      begin
        for (int t = 0; t < NUM_ROB; t++)
        begin
          if (pending[t] && rob_age(t, rob_head) > rob_age(rollback_idx, rob_head))
          begin
            pending[t]  = 1'b0;
            squashed[t] = 1'b1;
            squash_count++;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    int               fd;
    int               code;
    int               n;
    logic [8*12-1:0]  word;
    logic [8*128-1:0] line_buf;
    rob_idx_t         tag;
    pr_idx_t          dest;
    operand_t         mc;
    operand_t         mp;
    product_t         prod;
    reset         = 1'b1;
    issue_valid   = 1'b0;
    issue_rob_idx = '0;
    issue_dest_pr = '0;
    issue_mcand   = '0;
    issue_mplier  = '0;
    rob_head      = '0;
    rollback_en   = 1'b0;
    rollback_idx  = '0;
    for (int t = 0; t < NUM_ROB; t++)
    begin
      pending[t]  = 1'b0;
      squashed[t] = 1'b0;
      isolated[t] = 1'b0;
    end
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      $display("cannot open stimulus file %s", STIM_FILE);
      $display("test failed");
      $fatal(1, "no stimulus");
    end
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check("cdb_valid after reset", 64'(0), 64'(cdb_valid));
    check("issue_ready after reset", 64'(1), 64'(issue_ready));

    code = $fscanf(fd, "%s", word);
    while (code == 1)
    begin
      if (word == "#")
        code = $fgets(line_buf, fd);  // column notes
      else if (word == "issue")
      begin
        code = $fscanf(fd, "%h %h %h %h %h", tag, dest, mc, mp, prod);
        cycle_limit += 4 * NUM_STAGE;
        send_issue(tag, dest, mc, mp, prod);
      end
      else if (word == "wait")
      begin
        code = $fscanf(fd, "%d", n);
        cycle_limit += n;
        idle_cycles(n);
      end
      else if (word == "head")
      begin
        code = $fscanf(fd, "%h", tag);
        move_head(tag);
      end
      else if (word == "rollback")
      begin
        code = $fscanf(fd, "%h", tag);
        send_rollback(tag);
      end
      else
      begin
        $display("unknown stimulus line starting with %0s", word);
        $display("test failed");
        $fatal(1, "bad stimulus file");
      end
      code = $fscanf(fd, "%s", word);
    end
    $fclose(fd);

    cycle_limit += DRAIN;
    idle_cycles(DRAIN);
    for (int t = 0; t < NUM_ROB; t++)
      check($sformatf("pending at end tag %0d", t), 64'(0), 64'(pending[t]));
    check("ops accounted", 64'(issue_count), 64'(done_count + squash_count));
    if (u_mult_cluster.u_assert.error_count == 0)
    begin
      $display("test passed");
      $finish;
    end
    else
    begin
      $display("%0d protocol assertions fired", u_mult_cluster.u_assert.error_count);
      $display("test failed");
      $fatal(1, "protocol assertions failed");
    end
  end

endmodule

`default_nettype wire

//--- verif/mult_cluster_assert.sv
// protocol checker on the multiply cluster issue port, rollback and result bus
`timescale 1ns/10ps
`default_nettype none

module mult_cluster_assert #(
  parameter int NUM_MULT = 3
) (
  input logic                clock,
  input logic                reset,
  input logic                issue_valid,
  input logic                issue_ready,
  input logic                rollback_en,
  input logic [NUM_MULT-1:0] start,
  input logic [NUM_MULT-1:0] grant,
  input logic                cdb_valid
);

  int error_count = 0;  // failure tally for the testbench

  //////////////////////////////////////////////////
  // issue side
  //////////////////////////////////////////////////

  a_issue_ready: assert property (@(posedge clock) disable iff (reset)
    issue_valid |-> issue_ready)
  else
  begin
    $error("issue strobe while issue_ready is low");
    error_count++;
  end

  a_no_issue_on_rollback: assert property (@(posedge clock) disable iff (reset)
    !(issue_valid && rollback_en))
  else
  begin
    $error("issue strobe in a rollback cycle");
    error_count++;
  end

  a_start_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(start))
  else
  begin
    $error("more than one unit started");
    error_count++;
  end

  //////////////////////////////////////////////////
  // result bus
  //////////////////////////////////////////////////

  a_grant_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(grant))
  else
  begin
    $error("more than one unit granted");
    error_count++;
  end

  a_valid_has_grant: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> (grant != '0))
  else
  begin
    $error("bus valid without a grant");
    error_count++;
  end

endmodule

bind mult_cluster mult_cluster_assert #(
  .NUM_MULT (NUM_MULT)
) u_assert (
  .clock       (clock),
  .reset       (reset),
  .issue_valid (issue_valid),
  .issue_ready (issue_ready),
  .rollback_en (rollback_en),
  .start       (start),
  .grant       (grant),
  .cdb_valid   (cdb_valid)
);

`default_nettype wire

//--- verilog/mult_cluster.sv
// multiply execution cluster with issue steering, unit array and result bus
`timescale 1ns/10ps
`default_nettype none

module mult_cluster #(
  parameter int NUM_MULT  = 3,
  parameter int NUM_STAGE = 4
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               issue_valid,
  input  mult_pkg::rob_idx_t issue_rob_idx,
  input  mult_pkg::pr_idx_t  issue_dest_pr,
  input  mult_pkg::operand_t issue_mcand,
  input  mult_pkg::operand_t issue_mplier,
  input  mult_pkg::rob_idx_t rob_head,
  input  logic               rollback_en,
  input  mult_pkg::rob_idx_t rollback_idx,
  output logic               issue_ready,
  output logic               cdb_valid,
  output mult_pkg::rob_idx_t cdb_rob_idx,
  output mult_pkg::pr_idx_t  cdb_dest_pr,
  output mult_pkg::product_t cdb_value
);

  import mult_pkg::*;

  logic [NUM_MULT-1:0] unit_ready;
  logic [NUM_MULT-1:0] start;       // one-hot, from issue
  logic [NUM_MULT-1:0] unit_done;
  logic [NUM_MULT-1:0] grant;       // one-hot, from arbiter
  rob_idx_t            unit_rob_idx [NUM_MULT];
  pr_idx_t             unit_dest_pr [NUM_MULT];
  product_t            unit_value   [NUM_MULT];

  //////////////////////////////////////////////////
  // issue
  //////////////////////////////////////////////////

  mult_issue #(
    .NUM_MULT (NUM_MULT)
  ) u_issue (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .unit_ready  (unit_ready),
    .start       (start),
    .issue_ready (issue_ready)
  );

  //////////////////////////////////////////////////
  // multiplier array
  //////////////////////////////////////////////////

  // op data fans out, start picks the unit
  for (genvar i = 0; i < NUM_MULT; i++)
  begin : g_unit
    mult_unit #(
      .NUM_STAGE (NUM_STAGE)
    ) u_unit (
      .clock        (clock),
      .reset        (reset),
      .start        (start[i]),
      .rob_idx      (issue_rob_idx),
      .dest_pr      (issue_dest_pr),
      .mcand        (issue_mcand),
      .mplier       (issue_mplier),
      .rollback_en  (rollback_en),
      .rollback_idx (rollback_idx),
      .rob_head     (rob_head),
      .grant        (grant[i]),
      .ready        (unit_ready[i]),
      .done         (unit_done[i]),
      .done_rob_idx (unit_rob_idx[i]),
      .done_dest_pr (unit_dest_pr[i]),
      .done_value   (unit_value[i])
    );
  end

  //////////////////////////////////////////////////
  // result bus
  //////////////////////////////////////////////////

  cdb_arbiter #(
    .NUM_MULT (NUM_MULT)
  ) u_arbiter (
    .clock        (clock),
    .reset        (reset),
    .unit_done    (unit_done),
    .unit_rob_idx (unit_rob_idx),
    .unit_dest_pr (unit_dest_pr),
    .unit_value   (unit_value),
    .grant        (grant),
    .cdb_valid    (cdb_valid),
    .cdb_rob_idx  (cdb_rob_idx),
    .cdb_dest_pr  (cdb_dest_pr),
    .cdb_value    (cdb_value)
  );

endmodule

`default_nettype wire

//--- verilog/cdb_arbiter.sv
// round-robin common data bus arbiter over the finished multipliers
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter #(
  parameter int NUM_MULT = 3
) (
  input  logic                clock,
  input  logic                reset,
  input  logic [NUM_MULT-1:0] unit_done,
  input  mult_pkg::rob_idx_t  unit_rob_idx [NUM_MULT],
  input  mult_pkg::pr_idx_t   unit_dest_pr [NUM_MULT],
  input  mult_pkg::product_t  unit_value   [NUM_MULT],
  output logic [NUM_MULT-1:0] grant,
  output logic                cdb_valid,
  output mult_pkg::rob_idx_t  cdb_rob_idx,
  output mult_pkg::pr_idx_t   cdb_dest_pr,
  output mult_pkg::product_t  cdb_value
);

  import mult_pkg::*;

  localparam int PTR_W = (NUM_MULT > 1) ? $clog2(NUM_MULT) : 1;

  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] win;
  logic             found;

  always_comb
  begin
    int idx;
    found = 1'b0;
    win   = '0;
    for (int k = 0; k < NUM_MULT; k++)
    begin
      idx = (int'(ptr) + k) % NUM_MULT;
      if (!found && unit_done[idx])
      begin
        found = 1'b1;
        win   = PTR_W'(idx);
      end
    end
  end

  // bus mux, idle bus reads zero
  always_comb
  begin
    grant       = '0;
    cdb_rob_idx = '0;
    cdb_dest_pr = '0;
    cdb_value   = product_t'(0);
    if (found)
    begin
      grant[win]  = 1'b1;
      cdb_rob_idx = unit_rob_idx[win];
      cdb_dest_pr = unit_dest_pr[win];
      cdb_value   = unit_value[win];
    end
  end

  assign cdb_valid = found;

  always_ff @(posedge clock)
  begin
    if (reset)
      ptr <= '0;
    else if (found)
      ptr <= (int'(win) == NUM_MULT - 1) ? '0 : win + 1'b1;  // past the winner
  end

endmodule

`default_nettype wire

//--- verilog/mult_issue.sv
// issue stage that steers each multiply to a free unit by rotating priority
`timescale 1ns/10ps
`default_nettype none

module mult_issue #(
  parameter int NUM_MULT = 3
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                issue_valid,
  input  logic [NUM_MULT-1:0] unit_ready,
  output logic [NUM_MULT-1:0] start,
  output logic                issue_ready
);

  localparam int PTR_W = (NUM_MULT > 1) ? $clog2(NUM_MULT) : 1;

  logic [PTR_W-1:0] ptr;    // first unit to look at
  logic [PTR_W-1:0] pick;   // chosen unit
  logic             found;

  // first ready unit at or after the pointer
  always_comb
  begin
    int idx;
    found = 1'b0;
    pick  = '0;
    for (int k = 0; k < NUM_MULT; k++)
    begin
      idx = (int'(ptr) + k) % NUM_MULT;
      if (!found && unit_ready[idx])
      begin
        found = 1'b1;
        pick  = PTR_W'(idx);
      end
    end
  end

  always_comb
  begin
    start = '0;
    if (issue_valid && found)
      start[pick] = 1'b1;
  end

  assign issue_ready = |unit_ready;  // low only when all units frozen

  // move past the unit just started
  always_ff @(posedge clock)
  begin
    if (reset)
      ptr <= '0;
    else if (issue_valid && found)
    begin
      if (int'(pick) == NUM_MULT - 1)
        ptr <= '0;
      else
        ptr <= pick + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mult_unit.sv
// pipelined shift-add multiplier with tag tracking, result hold and rollback squash
`timescale 1ns/10ps
`default_nettype none

module mult_unit #(
  parameter int NUM_STAGE = 4
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               start,
  input  mult_pkg::rob_idx_t rob_idx,
  input  mult_pkg::pr_idx_t  dest_pr,
  input  mult_pkg::operand_t mcand,
  input  mult_pkg::operand_t mplier,
  input  logic               rollback_en,
  input  mult_pkg::rob_idx_t rollback_idx,
  input  mult_pkg::rob_idx_t rob_head,
  input  logic               grant,
  output logic               ready,
  output logic               done,
  output mult_pkg::rob_idx_t done_rob_idx,
  output mult_pkg::pr_idx_t  done_dest_pr,
  output mult_pkg::product_t done_value
);

  import mult_pkg::*;

  localparam int CHUNK = XLEN / NUM_STAGE;  // multiplier bits per stage

  // distance from the rob head, wraps with the tag width
  function automatic rob_idx_t age_of(rob_idx_t tag, rob_idx_t head);
    return tag - head;
  endfunction

  //////////////////////////////////////////////////
  // stage registers
  //////////////////////////////////////////////////

  logic [NUM_STAGE-1:0] s_valid;
  rob_idx_t             s_rob    [NUM_STAGE];
  pr_idx_t              s_pr     [NUM_STAGE];
  operand_t             s_mcand  [NUM_STAGE];
  operand_t             s_mplier [NUM_STAGE];
  product_t             s_sum    [NUM_STAGE];
  product_t             next_sum [NUM_STAGE];  // sum leaving each stage

  logic     hold_valid;
  rob_idx_t hold_rob;
  pr_idx_t  hold_pr;
  product_t hold_value;

  logic                 stall;
  logic [NUM_STAGE-1:0] kill;
  logic                 kill_hold;
  rob_idx_t             rb_age;

  assign stall = hold_valid && !grant;  // held result not taken
  assign ready = !stall;

  // stage k folds in multiplier bits [k*CHUNK +: CHUNK]
  always_comb
  begin
    for (int k = 0; k < NUM_STAGE; k++)
    begin
      next_sum[k] = s_sum[k];
      for (int j = 0; j < CHUNK; j++)
      begin
        if (s_mplier[k][k*CHUNK + j])
          next_sum[k] = next_sum[k] + (product_t'(s_mcand[k]) << (k*CHUNK + j));
      end
    end
  end

  //////////////////////////////////////////////////
  // rollback squash
  //////////////////////////////////////////////////

  assign rb_age = age_of(rollback_idx, rob_head);

  always_comb
  begin
    for (int k = 0; k < NUM_STAGE; k++)
      kill[k] = rollback_en && s_valid[k] && (age_of(s_rob[k], rob_head) > rb_age);
    // a granted hold is on the bus now and counts as done
    kill_hold = rollback_en && hold_valid && (age_of(hold_rob, rob_head) > rb_age);
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      s_valid    <= '0;
      hold_valid <= 1'b0;
    end
    else if (!stall)
    begin
      s_valid[0] <= start;
      for (int k = 1; k < NUM_STAGE; k++)
        s_valid[k] <= s_valid[k-1] && !kill[k-1];
      hold_valid <= s_valid[NUM_STAGE-1] && !kill[NUM_STAGE-1];
    end
    else
    begin
      s_valid    <= s_valid & ~kill;  // frozen, squash in place
      hold_valid <= hold_valid && !kill_hold;
    end
  end

  // payload moves with the valids
  always_ff @(posedge clock)
  begin
    if (!stall)
    begin
      s_rob[0]    <= rob_idx;
      s_pr[0]     <= dest_pr;
      s_mcand[0]  <= mcand;
      s_mplier[0] <= mplier;
      s_sum[0]    <= '0;
      for (int k = 1; k < NUM_STAGE; k++)
      begin
        s_rob[k]    <= s_rob[k-1];
        s_pr[k]     <= s_pr[k-1];
        s_mcand[k]  <= s_mcand[k-1];
        s_mplier[k] <= s_mplier[k-1];
        s_sum[k]    <= next_sum[k-1];
      end
      hold_rob   <= s_rob[NUM_STAGE-1];
      hold_pr    <= s_pr[NUM_STAGE-1];
      hold_value <= next_sum[NUM_STAGE-1];  // last chunk added here
    end
  end

  assign done         = hold_valid;
  assign done_rob_idx = hold_rob;
  assign done_dest_pr = hold_pr;
  assign done_value   = hold_value;

endmodule

`default_nettype wire

//--- verilog/mult_pkg.sv
// multiply cluster shared widths and tag types
`default_nettype none

package mult_pkg;

  //////////////////////////////////////////////////
  // core sizes
  //////////////////////////////////////////////////

  localparam int XLEN    = 32;  // operand width
  localparam int NUM_ROB = 16;  // reorder buffer entries
  localparam int NUM_PR  = 64;  // physical registers

  localparam int ROB_W = $clog2(NUM_ROB);
  localparam int PR_W  = $clog2(NUM_PR);

  //////////////////////////////////////////////////
  // data and tag types
  //////////////////////////////////////////////////

  // one multiplicand or multiplier
  typedef logic [XLEN-1:0] operand_t;

  // full unsigned product, also the bus value
  typedef logic [2*XLEN-1:0] product_t;

  // rob tag, head and rollback index share this
  typedef logic [ROB_W-1:0] rob_idx_t;

  typedef logic [PR_W-1:0] pr_idx_t;  // destination physical register

endpackage

`default_nettype wire
